//--- source/chipBusPkg.sv
/* Chip bus bridge shared types
   Request, data word views, register space constants and sequencer states */

`default_nettype none

package chipBusPkg;

    ////////////////////////////////////////////////////////////
    // Register space and size codes
    ////////////////////////////////////////////////////////////

    localparam logic [11:0] REG_SPACE_BASE = 12'hDFF;  // Custom chip registers at 0xDFFxxx

    localparam logic [1:0] SIZ_LONG = 2'b00;  // 68040 SIZ1:SIZ0 encoding
    localparam logic [1:0] SIZ_BYTE = 2'b01;
    localparam logic [1:0] SIZ_WORD = 2'b10;

    ////////////////////////////////////////////////////////////
    // Data words
    ////////////////////////////////////////////////////////////

    // Two chip bus words inside one CPU long
    typedef struct packed {
        logic [15:0] hi;  // D31:16, even word address
        logic [15:0] lo;  // D15:0, odd word address
    } chipWordPair_t;

    // CPU data seen as one long or as two chip words
    typedef union packed {
        logic [31:0]   lng;
        chipWordPair_t words;
    } cpuWord_u;

    // Latched CPU request
    typedef struct packed {
        logic [23:0] addr;   // Byte address
        logic        rnw;    // 1 = read
        logic [1:0]  siz;    // Transfer size
        logic [31:0] wdata;  // Write data as the CPU drives it
    } cpuReq_t;

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    // 68000 states, named after the bus cycle state they stand for
    typedef enum logic [2:0] {
        ST2_IDLE  = 3'd0,  // Waiting for a request with C1 and C3 low
        ST4_WAIT  = 3'd1,  // Waiting for C1 and C3 high, DMA stall
        ST5_LATCH = 3'd2,  // Early read latch point
        ST6_HOLD  = 3'd3,
        ST7_END   = 3'd4   // Strobes drop here
    } regState_t;

    // Chip bus strobes, active high inside the bridge
    typedef struct packed {
        logic as;
        logic uds;
        logic lds;
        logic regEn;
    } chipStrobe_t;

    // Synchronized colour clocks and DMA request
    typedef struct packed {
        logic c1;
        logic c3;
        logic dbrIdle;  // nDBR seen high on both flops
    } colorPhase_t;

endpackage

`default_nettype wire

//--- source/colorClockSync.sv
/* Colour clock and DMA request synchronizers into the CLK40 domain */

`default_nettype none

module colorClockSync import chipBusPkg::*; (
    input  wire         CLK40,
    input  wire         nRESET,
    input  wire         c1,      // Colour clock C1 from Agnus
    input  wire         c3,      // Colour clock C3, quadrature to C1
    input  wire         nDbr,    // DMA bus request, low while Agnus owns the bus
    output colorPhase_t phase
);

    logic [1:0] c1Sync;   // [1] is the stable copy
    logic [1:0] c3Sync;
    logic [1:0] dbrSync;

    // Colour clocks sampled on the falling edge, half a cycle ahead of the sequencer
    always_ff @(negedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            c1Sync <= 2'b11;  // High on both keeps the sequencer out of state 2 start
            c3Sync <= 2'b11;
        end else begin
            c1Sync <= {c1Sync[0], c1};
            c3Sync <= {c3Sync[0], c3};
        end
    end

    // DMA request on the rising edge
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            dbrSync <= 2'b00;  // Bus taken until proven otherwise
        end else begin
            dbrSync <= {dbrSync[0], nDbr};
        end
    end

    assign phase.c1      = c1Sync[1];
    assign phase.c3      = c3Sync[1];
    assign phase.dbrIdle = &dbrSync;  // Both flops must agree

endmodule

`default_nettype wire

//--- source/regRequestLatch.sv
/* CPU request capture for the custom register space
   Holds the request for the whole chip cycle, with room for one early follow-up */

`default_nettype none

module regRequestLatch import chipBusPkg::*; (
    input  wire         CLK40,
    input  wire         nRESET,
    input  wire         ts,       // Transfer start, one cycle
    input  wire  [23:0] addr,
    input  wire         rnw,
    input  wire  [1:0]  siz,
    input  wire  [31:0] wdata,
    input  wire         done,     // Sequencer back in state 2
    output cpuReq_t     req,
    output logic        pending   // Registered register space select
);

    logic    hit;         // ts inside 0xDFFxxx
    cpuReq_t incoming;
    cpuReq_t queuedReq;   // Follow-up taken after an early read ta
    logic    queued;

    assign hit      = ts && (addr[23:12] == REG_SPACE_BASE);
    assign incoming = '{addr: addr, rnw: rnw, siz: siz, wdata: wdata};

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    // A read ends at ta in state 5 but the chip cycle runs on to state 7,
    // so the next ts can arrive while pending is still set
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            pending <= 1'b0;
            queued  <= 1'b0;
        end else if (done) begin
            pending <= queued || hit;  // Chain straight into the next cycle
            queued  <= 1'b0;
        end else if (hit) begin
            if (pending) queued <= 1'b1;
            else         pending <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Payload
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (done && queued) begin
            req <= queuedReq;
        end else if (hit && (!pending || done)) begin
            req <= incoming;
        end
        if (hit && pending && !done) queuedReq <= incoming;  // Parked until done
    end

endmodule

`default_nettype wire

//--- source/chipRegCycle.sv
/* MC68000 style register cycle sequencer on the colour clocks
   Drives AS, UDS, LDS, REGEN, the early read latch and the CPU acknowledge */

`default_nettype none

module chipRegCycle import chipBusPkg::*; (
    input  wire         CLK40,
    input  wire         nRESET,
    input  colorPhase_t phase,      // Synchronized C1, C3, DMA idle
    input  wire         casAgnus,   // Agnus chip RAM CAS, high stalls us
    input  wire         pending,    // Request waiting in the latch
    input  cpuReq_t     req,
    output chipStrobe_t strobes,
    output logic        readLatch,  // Capture read data this cycle
    output logic        ta,         // Transfer acknowledge, one cycle
    output logic        done        // First cycle back in state 2
);

    regState_t state;

    logic asEn;
    logic dsEn;       // Data strobe phase
    logic udsSel;     // Lane picks, fixed at start
    logic ldsSel;
    logic regEn;
    logic readCycle;  // rnw held for the whole cycle

    logic bothLanes;
    logic udsNext;
    logic ldsNext;
    logic startNow;

    ////////////////////////////////////////////////////////////
    // Byte lane selection
    ////////////////////////////////////////////////////////////

    // Reads and word or long writes use the full word
    assign bothLanes = req.rnw || (req.siz == SIZ_WORD) || (req.siz == SIZ_LONG);
    // A byte write picks UDS on even and LDS on odd addresses
    assign udsNext = bothLanes || ((req.siz == SIZ_BYTE) && !req.addr[0]);
    assign ldsNext = bothLanes || ((req.siz == SIZ_BYTE) && req.addr[0]);

    // Cycles only begin with both colour clocks low
    // The done cycle still sees the old pending, so it is skipped
    assign startNow = pending && !done && !phase.c1 && !phase.c3;

    // Early read latch on the state 5 to state 6 edge
    assign readLatch = (state == ST5_LATCH) && !phase.c1 && phase.c3 && readCycle;

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            state     <= ST2_IDLE;
            asEn      <= 1'b0;
            dsEn      <= 1'b0;
            udsSel    <= 1'b0;
            ldsSel    <= 1'b0;
            regEn     <= 1'b0;
            readCycle <= 1'b1;
            ta        <= 1'b0;
            done      <= 1'b0;
        end else begin
            ta   <= 1'b0;  // Pulses by default
            done <= 1'b0;

            case (state)
                ST2_IDLE: begin
                    if (startNow) begin
                        asEn      <= 1'b1;
                        regEn     <= 1'b1;
                        udsSel    <= udsNext;
                        ldsSel    <= ldsNext;
                        dsEn      <= req.rnw;  // Reads strobe together with AS
                        readCycle <= req.rnw;
                        state     <= ST4_WAIT;
                    end
                end

                ST4_WAIT: begin
                    // Write data strobes come up with both clocks high
                    if (phase.c1 && phase.c3) begin
                        dsEn <= 1'b1;
                        // Agnus DMA and CAS always win, wait here
                        if (phase.dbrIdle && !casAgnus) begin
                            state <= ST5_LATCH;
                        end
                    end
                end

                ST5_LATCH: begin
                    if (!phase.c1 && phase.c3) begin
                        ta    <= readCycle;  // Early read termination
                        state <= ST6_HOLD;
                    end
                end

                ST6_HOLD: begin
                    if (!phase.c1 && !phase.c3) state <= ST7_END;
                end

                ST7_END: begin
                    if (phase.c1 && !phase.c3) begin
                        asEn  <= 1'b0;
                        dsEn  <= 1'b0;
                        regEn <= 1'b0;
                        done  <= 1'b1;
                        ta    <= !readCycle;  // Writes finish only now
                        state <= ST2_IDLE;
                    end
                end

                default: state <= ST2_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Strobe outputs
    ////////////////////////////////////////////////////////////

    assign strobes.as    = asEn;
    assign strobes.uds   = udsSel && dsEn;
    assign strobes.lds   = ldsSel && dsEn;
    assign strobes.regEn = regEn;

endmodule

`default_nettype wire

//--- source/chipDataPath.sv
/* Data steering between the 32 bit CPU bus and the 16 bit chip bus
   Write word select, early read capture and register word address */

`default_nettype none

module chipDataPath import chipBusPkg::*; (
    input  wire         CLK40,
    input  wire         nRESET,
    input  cpuReq_t     req,
    input  wire         regEn,          // Register cycle in progress
    input  wire         readLatch,      // Capture chipDataIn now
    input  wire  [15:0] chipDataIn,
    output logic [15:0] chipDataOut,
    output logic        chipDataOutEn,
    output logic [7:0]  regAddr,        // Register word address
    output logic [31:0] rdata
);

    cpuWord_u writeWord;  // CPU write data, split view
    cpuWord_u readWord;   // Chip word copied to both halves

    ////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////

    assign writeWord.lng = req.wdata;

    // A1 low puts the register on D31:16, A1 high on D15:0
    // Byte writes land on the right chip byte through UDS and LDS
    always_comb begin
        if (req.addr[1]) begin
            chipDataOut = writeWord.words.lo;
        end else begin
            chipDataOut = writeWord.words.hi;
        end
    end

    assign chipDataOutEn = regEn && !req.rnw;  // Drive only during write cycles

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////

    // Register words can be read on either half of the 68040 bus
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            readWord.lng <= 32'h0;
        end else if (readLatch) begin
            readWord.words.hi <= chipDataIn;
            readWord.words.lo <= chipDataIn;
        end
    end

    assign rdata = readWord.lng;  // Holds until the next read

    ////////////////////////////////////////////////////////////
    // Address
    ////////////////////////////////////////////////////////////

    assign regAddr = req.addr[8:1];  // RGA word index inside 0xDFF000

endmodule

`default_nettype wire

//--- source/chipBusBridge.sv
/* CPU to custom chip register bridge, top level
   Joins synchronizers, request latch, 68000 sequencer and datapath */

`default_nettype none

module chipBusBridge import chipBusPkg::*; (
    input  wire         CLK40,
    input  wire         nRESET,
    // Agnus side timing
    input  wire         c1,
    input  wire         c3,
    input  wire         nDbr,
    input  wire         casAgnus,
    // CPU side
    input  wire         ts,
    input  wire  [23:0] addr,
    input  wire         rnw,
    input  wire  [1:0]  siz,
    input  wire  [31:0] wdata,
    output logic        ta,
    output logic [31:0] rdata,
    // Chip bus
    output logic        nAs,
    output logic        nUds,
    output logic        nLds,
    output logic        nRegEn,
    input  wire  [15:0] chipDataIn,
    output logic [15:0] chipDataOut,
    output logic        chipDataOutEn,
    output logic [7:0]  regAddr
);

    colorPhase_t phase;
    cpuReq_t     req;
    chipStrobe_t strobes;
    logic        pending;
    logic        readLatch;
    logic        done;

    colorClockSync sync0 (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .c1     (c1),
        .c3     (c3),
        .nDbr   (nDbr),
        .phase  (phase)
    );

    regRequestLatch latch0 (
        .CLK40   (CLK40),
        .nRESET  (nRESET),
        .ts      (ts),
        .addr    (addr),
        .rnw     (rnw),
        .siz     (siz),
        .wdata   (wdata),
        .done    (done),
        .req     (req),
        .pending (pending)
    );

    chipRegCycle cycle0 (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .phase     (phase),
        .casAgnus  (casAgnus),
        .pending   (pending),
        .req       (req),
        .strobes   (strobes),
        .readLatch (readLatch),
        .ta        (ta),
        .done      (done)
    );

    chipDataPath data0 (
        .CLK40         (CLK40),
        .nRESET        (nRESET),
        .req           (req),
        .regEn         (strobes.regEn),
        .readLatch     (readLatch),
        .chipDataIn    (chipDataIn),
        .chipDataOut   (chipDataOut),
        .chipDataOutEn (chipDataOutEn),
        .regAddr       (regAddr),
        .rdata         (rdata)
    );

    // Active low pins
    assign nAs    = !strobes.as;
    assign nUds   = !strobes.uds;
    assign nLds   = !strobes.lds;
    assign nRegEn = !strobes.regEn;

endmodule

`default_nettype wire

//--- test/chipBusModel.sv
/* Agnus stand-in for the bridge testbench
   Quadrature colour clocks, custom register file and DMA bus holds */

`default_nettype none

module chipBusModel (
    input  wire         CLK40,
    input  wire         nRESET,
    input  wire         dbrHold,        // Hold the bus with a DMA request
    input  wire         casHold,        // Hold the bus with a chip RAM CAS
    input  wire         nUds,
    input  wire         nLds,
    input  wire         nRegEn,
    input  wire  [7:0]  regAddr,
    input  wire  [15:0] chipDataOut,
    input  wire         chipDataOutEn,
    output logic        c1,
    output logic        c3,
    output logic        nDbr,
    output logic        casAgnus,
    output logic [15:0] chipDataIn
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] regFile [256];  // Custom register contents
    logic [1:0]  divCount;       // Three CLK40 cycles per quarter
    logic [1:0]  quarter;        // C1,C3 as 0 LL, 1 HL, 2 HH, 3 LH

    // Power up contents, every word different
    initial begin
        for (int i = 0; i < 256; i++) begin
            regFile[i] <= {~8'(i), 8'(i) ^ 8'h3C};
        end
    end

    ////////////////////////////////////////////////////////////
    // Colour clocks
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            divCount <= 2'd0;
            quarter  <= 2'd0;
        end else if (divCount == 2'd2) begin
            divCount <= 2'd0;
            quarter  <= quarter + 2'd1;  // Next quarter of the colour clock
        end else begin
            divCount <= divCount + 2'd1;
        end
    end

    assign c1 = quarter[0] ^ quarter[1];  // High in quarters 1 and 2
    assign c3 = quarter[1];               // High in quarters 2 and 3

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////

    // Writes land byte by byte under UDS and LDS
    always @(posedge CLK40) begin
        if (chipDataOutEn && !nRegEn) begin
            if (!nUds) regFile[regAddr][15:8] <= chipDataOut[15:8];
            if (!nLds) regFile[regAddr][7:0]  <= chipDataOut[7:0];
        end
    end

    // Read data only while REGEN is low on a read cycle
    assign chipDataIn = (!nRegEn && !chipDataOutEn) ? regFile[regAddr] : 16'h0000;
    assign nDbr       = !dbrHold;
    assign casAgnus   = casHold;

endmodule

`default_nettype wire

//--- test/chipBusBridgeTb.sv
/* Testbench for the chip register bridge
   LFSR driven CPU accesses checked against a reference register file */

`default_nettype none

module chipBusBridgeTb import chipBusPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TA_TIMEOUT   = 400;  // CLK40 cycles, room for a queued cycle
    localparam int IDLE_TIMEOUT = 200;
    localparam int OUTSIDE_WAIT = 80;   // Over six colour clock periods

    logic        CLK40;
    logic        nRESET;
    logic        c1, c3, nDbr, casAgnus;  // From the Agnus model
    logic        dbrHold, casHold;        // DMA window requests to the model
    logic        ts, rnw, ta;
    logic [23:0] addr;
    logic [1:0]  siz;
    logic [31:0] wdata, rdata;
    logic        nAs, nUds, nLds, nRegEn, chipDataOutEn;
    logic [15:0] chipDataIn, chipDataOut;
    logic [7:0]  regAddr;

    logic [15:0] refFile [256];  // Expected register contents
    logic [15:0] lfsr = 16'd89;
    logic        lastTa;
    int          errors, testBase, testNum, failedTests;
    int          taCount, expectedTa;  // Pulses seen and pulses owed

    chipBusBridge dut0 (.*);
    chipBusModel model0 (.*);

    initial begin
        CLK40 = 1'b0;
        forever #10 CLK40 = ~CLK40;  // 20 ns period
    end

    ////////////////////////////////////////////////////////////
    // Random numbers and reference rules
    ////////////////////////////////////////////////////////////

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);  // One step per bit
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [1:0] pickSize();
        logic [1:0] s;
        s = 2'(takeBits(2));
        return (s == 2'b11) ? SIZ_WORD : s;  // 11 has no meaning here
    endfunction

    function automatic logic [23:0] regAddress(input logic [1:0] s);
        logic [23:0] a;
        a = {REG_SPACE_BASE, 3'b000, 9'(takeBits(9))};
        if (s == SIZ_WORD) a[0] = 1'b0;
        if (s == SIZ_LONG) a[1:0] = 2'b00;
        return a;
    endfunction

    function automatic logic [23:0] outsideAddress();
        logic [23:0] a;
        a = 24'(takeBits(24));
        if (a[23:12] == REG_SPACE_BASE) a[23] = 1'b0;  // DFF turns into 5FF
        return a;
    endfunction

    // Chip word picked by A1, then UDS on even and LDS on odd byte addresses
    function automatic logic [15:0] mergeWrite(input logic [15:0] old, input logic [23:0] a,
                                              input logic [1:0] s, input logic [31:0] d);
        logic [15:0] w;
        w = a[1] ? d[15:0] : d[31:16];
        if (s != SIZ_BYTE) return w;
        return a[0] ? {old[15:8], w[7:0]} : {w[15:8], old[7:0]};
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("** Error %s = %h, expected %h at %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic reportProblem(input string msg);
        $display("Problem at %0t: %s", $time, msg);
        errors++;
    endtask

    // Rising edge plus 2 ns, where outputs are sampled and inputs driven
    task automatic step();
        @(posedge CLK40);
        #2;
        if (ta) taCount++;
        assert (!(ta && lastTa)) else reportProblem("ta stayed high for more than one cycle");
        lastTa = ta;
    endtask

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        while (!nAs && cycles < IDLE_TIMEOUT) begin
            step();
            cycles++;
        end
        assert (nAs) else reportProblem("chip bus never went idle");
    endtask

    // One register access, watched cycle by cycle until ta
    task automatic runTransfer(input logic [23:0] a, input logic r, input logic [1:0] s,
                               input logic [31:0] d, input int stallLen,
                               input logic [1:0] stallKind);
        logic [15:0] laneWord;  // Half of wdata the chip should see
        logic [15:0] expWord;
        logic        gotTa;
        logic        asSeen;
        logic        laneSeen;  // Write word seen on the chip bus
        int          cycles;
        if (stallLen > 0) waitIdle();
        laneWord = a[1] ? d[15:0] : d[31:16];
        expWord  = refFile[a[8:1]];
        gotTa    = 1'b0;
        asSeen   = 1'b0;
        laneSeen = 1'b0;
        cycles   = 0;
        {ts, addr, rnw, siz, wdata} = {1'b1, a, r, s, d};
        dbrHold  = (stallLen > 0) && stallKind[0];
        casHold  = (stallLen > 0) && stallKind[1];
        expectedTa++;
        while (!gotTa && cycles < stallLen + TA_TIMEOUT) begin
            step();
            cycles++;
            if (!nAs) asSeen = 1'b1;
            if (!r && chipDataOutEn && !nRegEn) begin
                laneSeen = 1'b1;
                assert (chipDataOut == laneWord)
                    else reportValue("chipDataOut", chipDataOut, laneWord);
            end
            if (cycles <= stallLen && asSeen)
                assert (!nAs) else reportValue("nAs", nAs, 0);  // Held in state 4
            if (ta) begin
                gotTa = 1'b1;
                assert (cycles > stallLen)
                    else reportProblem("ta arrived while Agnus held the bus");
                assert (nAs == !r) else reportValue("nAs", nAs, !r);  // Reads end early
                assert (regAddr == a[8:1]) else reportValue("regAddr", regAddr, a[8:1]);
                if (r) begin
                    assert (!chipDataOutEn) else reportValue("chipDataOutEn", chipDataOutEn, 0);
                    assert (rdata == {expWord, expWord})
                        else reportValue("rdata", rdata, {expWord, expWord});
                end else begin
                    assert (laneSeen)
                        else reportProblem("write data never driven on the chip bus");
                end
            end
            ts = 1'b0;
            if (cycles >= stallLen) {dbrHold, casHold} = 2'b00;
        end
        assert (gotTa) else begin
            reportProblem($sformatf("no ta for access to %h", a));
            {ts, dbrHold, casHold} = 3'b000;
        end
        if (gotTa && !r) refFile[a[8:1]] = mergeWrite(refFile[a[8:1]], a, s, d);
    endtask

    // Access outside 0xDFFxxx, the bus must stay quiet
    task automatic checkOutside(input logic [23:0] a);
        waitIdle();
        {ts, addr, rnw, siz, wdata} = {1'b1, a, 1'(takeBits(1)), pickSize(), takeBits(32)};
        for (int i = 0; i < OUTSIDE_WAIT; i++) begin
            step();
            assert (nAs) else reportValue("nAs", nAs, 1);
            assert (!ta) else reportValue("ta", ta, 0);
            ts = 1'b0;
        end
    endtask

    task automatic endTest(input string name);
        testNum++;
        if (errors != testBase) failedTests++;
        $display("Test %0d %s: %s, %0d errors", testNum, name,
                 (errors == testBase) ? "passed" : "failed", errors - testBase);
        testBase = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [23:0] a;
        logic [1:0]  s;
        logic [1:0]  kind;
        logic        r;
        int          stall;
        {nRESET, ts, addr, rnw, siz, wdata, dbrHold, casHold, lastTa} = '0;
        for (int i = 0; i < 256; i++) begin
            refFile[i] = {~8'(i), 8'(i) ^ 8'h3C};  // Same power up words as the model
        end

        // Reset held for 16 cycles, then idle pins checked a while longer
        for (int i = 0; i < 24; i++) begin
            step();
            assert ({nAs, nUds, nLds, nRegEn, ta, chipDataOutEn} == 6'b111100)
                else reportValue("{nAs,nUds,nLds,nRegEn,ta,chipDataOutEn}",
                                 {nAs, nUds, nLds, nRegEn, ta, chipDataOutEn}, 6'h3c);
            if (i == 15) nRESET = 1'b1;
        end
        endTest("reset");

        for (int i = 0; i < 8; i++) begin
            s = pickSize();
            a = regAddress(s);
            runTransfer(a, 1'b0, s, takeBits(32), 0, 2'b00);
            runTransfer({a[23:1], 1'b0}, 1'b1, SIZ_WORD, 32'h0, 0, 2'b00);
        end
        endTest("write then read");

        for (int i = 0; i < 4; i++) begin
            checkOutside(outsideAddress());
        end
        endTest("outside register space");

        for (int i = 0; i < 6; i++) begin
            s = pickSize();
            runTransfer(regAddress(s), 1'(i), s, takeBits(32), 20 + int'(takeBits(6)),
                        2'(i % 3 + 1));
        end
        endTest("DMA hold");

        for (int i = 0; i < 200; i++) begin
            if (takeBits(3) == 0) begin
                checkOutside(outsideAddress());
            end else begin
                s     = pickSize();
                a     = regAddress(s);
                r     = 1'(takeBits(1));
                stall = 0;
                kind  = 2'b00;
                if (takeBits(2) == 0) begin  // Roughly one in four gets a DMA window
                    stall = 8 + int'(takeBits(5));
                    kind  = 2'(takeBits(2));
                    if (kind == 2'b00) kind = 2'b01;
                end
                runTransfer(a, r, s, takeBits(32), stall, kind);
            end
        end
        waitIdle();
        for (int i = 0; i < 256; i++) begin
            assert (model0.regFile[i] == refFile[i])
                else reportValue($sformatf("regFile[%0d]", i), model0.regFile[i], refFile[i]);
        end
        assert (taCount == expectedTa) else reportValue("taCount", taCount, expectedTa);
        endTest("random transfers");

        $display("Tests run %0d, tests failed %0d, errors %0d", testNum, failedTests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/chipBusPkg.sv
source/colorClockSync.sv
source/regRequestLatch.sv
source/chipRegCycle.sv
source/chipDataPath.sv
source/chipBusBridge.sv
test/chipBusModel.sv
test/chipBusBridgeTb.sv

//--- Bender.yml
package:
  name: chipBusBridge

sources:
  - files:
      - source/chipBusPkg.sv
      - source/colorClockSync.sv
      - source/regRequestLatch.sv
      - source/chipRegCycle.sv
      - source/chipDataPath.sv
      - source/chipBusBridge.sv
  - target: test
    files:
      - test/chipBusModel.sv
      - test/chipBusBridgeTb.sv
